//--- files.f
hdl/ooo_pkg.sv
hdl/regfile.sv
hdl/reorder_buffer.sv
hdl/rename_core.sv
bench/tb_rename_core.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_rename_core
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/tb_rename_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rename_core;

    import ooo_pkg::*;

    localparam int ROB_DEPTH   = 7;
    localparam int CYCLE_LIMIT = 4000;           // Tests take about 1500

    logic   clk, rst, clr, in_en, in_pd, wb_en;
    regnm_t in_rs1, in_rs2, in_rd;
    op_t    in_op;
    pc_t    in_pc;
    imm_t   in_imm;
    tag_t   wb_tag;
    data_t  wb_data;

    logic   in_rdy, dp_en, dp_pd, cm_en;
    tag_t   dp_tag, dp_rs1_tag, dp_rs2_tag, cm_tag;
    data_t  dp_rs1_dt, dp_rs2_dt, cm_data;
    regnm_t dp_rd, cm_rd;
    op_t    dp_op;
    pc_t    dp_pc;
    imm_t   dp_imm;

    // Reference model state
    data_t  m_val [REG_NUM];
    tag_t   m_tag [REG_NUM];
    tag_t   tag_q [$];
    regnm_t rd_q [$];
    logic   slot_wait [1:ROB_DEPTH];
    logic   slot_done [1:ROB_DEPTH];
    data_t  slot_res  [1:ROB_DEPTH];
    int     tail_slot;
    int     cycles = 0;
    string  test_name;

    // Expected outputs, registered like the DUT
    logic               exp_dp_en, exp_rdy, exp_head_done;
    logic [14:0]        exp_ctl;                 // tag, rd, op, pd
    logic [63:0]        exp_pcimm;
    logic [34:0]        exp_rs1, exp_rs2;        // value, tag
    logic [39:0]        exp_cm;                  // tag, rd, data
    logic [ROB_DEPTH:1] pend_mask;
    int                 exp_cnt;

    rename_core #(.ROB_DEPTH(ROB_DEPTH)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "Run stopped by timeout");
        end
    end

    task automatic report_fail(input string what, input logic [63:0] exp, input logic [63:0] act);
        $display("FAIL %s %s: expected %0h actual %0h", test_name, what, exp, act);
        $display("STATUS: FAIL");
        $fatal(1, "Mismatch on %s", what);
    endtask

    always @(posedge clk) begin : model
        logic   accept;
        logic   commit;
        tag_t   t;
        regnm_t rd;
        accept = 1'b0;
        if (rst || clr) begin
            for (int i = 0; i < REG_NUM; i++) begin
                m_tag[i] = '0;
                if (rst) begin
                    m_val[i] = '0;             // Flush keeps values
                end
            end
            tag_q.delete();
            rd_q.delete();
            for (int k = 1; k <= ROB_DEPTH; k++) begin
                slot_wait[k] = 1'b0;
                slot_done[k] = 1'b0;
            end
            tail_slot = 0;
        end else begin
            accept = in_en && (tag_q.size() < ROB_DEPTH);
            commit = (tag_q.size() != 0) && slot_done[tag_q[0]];
            if (accept) begin
                exp_ctl   <= {tag_t'(tail_slot + 1), in_rd, in_op, in_pd};
                exp_pcimm <= {in_pc, in_imm};
                exp_rs1   <= {m_val[in_rs1], m_tag[in_rs1]};
                exp_rs2   <= {m_val[in_rs2], m_tag[in_rs2]};
            end
            if (wb_en && wb_tag != '0 && int'(wb_tag) <= ROB_DEPTH && slot_wait[wb_tag]) begin
                slot_wait[wb_tag] = 1'b0;
                slot_done[wb_tag] = 1'b1;
                slot_res[wb_tag]  = wb_data;
            end
            if (commit) begin
                t  = tag_q.pop_front();
                rd = rd_q.pop_front();
                slot_done[t] = 1'b0;
                if (rd != '0 && m_tag[rd] == t) begin
                    m_val[rd] = slot_res[t];
                    m_tag[rd] = '0;
                end
            end
            if (accept) begin
                t = tag_t'(tail_slot + 1);
                if (in_rd != '0 && in_op != OP_SB && in_op != OP_SH && in_op != OP_SW) begin
                    m_tag[in_rd] = t;              // Newest rename wins
                end
                tag_q.push_back(t);
                rd_q.push_back(in_rd);
                slot_wait[t] = 1'b1;
                tail_slot = (tail_slot + 1) % ROB_DEPTH;
            end
        end
        exp_dp_en     <= accept;
        exp_rdy       <= (tag_q.size() < ROB_DEPTH);
        exp_cnt       <= tag_q.size();
        exp_head_done <= (tag_q.size() != 0) && slot_done[tag_q[0]];
        if (tag_q.size() != 0) begin
            exp_cm <= {tag_q[0], rd_q[0], slot_res[tag_q[0]]};
        end
        for (int k = 1; k <= ROB_DEPTH; k++) begin
            pend_mask[k] <= slot_wait[k];
        end
    end

    ready_check: assert property (@(posedge clk) disable iff (rst) in_rdy == exp_rdy)
        else report_fail("in_rdy", 64'($sampled(exp_rdy)), 64'($sampled(in_rdy)));
    dispatch_en_check: assert property (@(posedge clk) disable iff (rst) dp_en == exp_dp_en)
        else report_fail("dp_en", 64'($sampled(exp_dp_en)), 64'($sampled(dp_en)));
    dispatch_ctl_check: assert property (@(posedge clk) disable iff (rst)
        exp_dp_en |-> {dp_tag, dp_rd, dp_op, dp_pd} == exp_ctl)
        else report_fail("dp tag/rd/op/pd", 64'($sampled(exp_ctl)),
                         64'($sampled({dp_tag, dp_rd, dp_op, dp_pd})));
    dispatch_pc_check: assert property (@(posedge clk) disable iff (rst)
        exp_dp_en |-> {dp_pc, dp_imm} == exp_pcimm)
        else report_fail("dp pc/imm", $sampled(exp_pcimm), $sampled({dp_pc, dp_imm}));
    rs1_check: assert property (@(posedge clk) disable iff (rst)
        exp_dp_en |-> {dp_rs1_dt, dp_rs1_tag} == exp_rs1)
        else report_fail("rs1 value/tag", 64'($sampled(exp_rs1)),
                         64'($sampled({dp_rs1_dt, dp_rs1_tag})));
    rs2_check: assert property (@(posedge clk) disable iff (rst)
        exp_dp_en |-> {dp_rs2_dt, dp_rs2_tag} == exp_rs2)
        else report_fail("rs2 value/tag", 64'($sampled(exp_rs2)),
                         64'($sampled({dp_rs2_dt, dp_rs2_tag})));
    commit_en_check: assert property (@(posedge clk) disable iff (rst)
        cm_en == (exp_head_done && !clr))
        else report_fail("cm_en", 64'($sampled(exp_head_done && !clr)), 64'($sampled(cm_en)));
    commit_check: assert property (@(posedge clk) disable iff (rst)
        cm_en |-> {cm_tag, cm_rd, cm_data} == exp_cm)
        else report_fail("cm tag/rd/data", 64'($sampled(exp_cm)),
                         64'($sampled({cm_tag, cm_rd, cm_data})));

    task automatic next_issue(input int pct);
        if (!(in_en && !exp_rdy)) begin            // Held until accepted
            in_en  <= ($urandom_range(0, 99) < pct);
            in_rs1 <= regnm_t'($urandom_range(0, 7));
            in_rs2 <= regnm_t'($urandom_range(0, 7));
            in_rd  <= regnm_t'($urandom_range(0, 7));
            in_op  <= ($urandom_range(0, 3) == 0) ? OP_SB + op_t'($urandom_range(0, 2))
                                                  : op_t'($urandom_range(0, 24));
            in_pc  <= $urandom;
            in_imm <= $urandom;
            in_pd  <= 1'($urandom_range(0, 1));
        end
    endtask

    task automatic next_writeback(input bit bogus);
        tag_t pick [$];
        for (int k = 1; k <= ROB_DEPTH; k++) begin
            if (pend_mask[k]) begin
                pick.push_back(tag_t'(k));
            end
        end
        wb_data <= $urandom;
        if (bogus && $urandom_range(0, 15) == 0) begin
            wb_en  <= 1'b1;
            wb_tag <= tag_t'($urandom_range(0, 7));   // Mostly not WAITING
        end else if (pick.size() != 0) begin
            wb_en  <= 1'b1;
            wb_tag <= pick[$urandom_range(0, pick.size() - 1)];
        end else begin
            wb_en  <= 1'b0;
        end
    endtask

    task automatic issue_one(input regnm_t rs1, input regnm_t rs2, input regnm_t rd,
                             input op_t op);
        in_en  <= 1'b1;
        in_rs1 <= rs1;
        in_rs2 <= rs2;
        in_rd  <= rd;
        in_op  <= op;
        do begin
            @(posedge clk);
            next_writeback(1'b0);
        end while (!exp_rdy);
        in_en <= 1'b0;
    endtask

    task automatic drain();
        clr <= 1'b0;
        do begin
            @(posedge clk);
            next_issue(0);
            next_writeback(1'b0);
        end while (exp_cnt != 0 || in_en);
        wb_en <= 1'b0;
    endtask

    task automatic sweep_registers();
        for (int i = 0; i < REG_NUM; i += 2) begin
            issue_one(regnm_t'(i), regnm_t'(i + 1), regnm_t'(i), OP_SW);
        end
    endtask

    initial begin
        void'($urandom(32'hd113));
        rst     = 1'b1;
        clr     = 1'b0;
        in_en   = 1'b0;
        in_rs1  = '0;
        in_rs2  = '0;
        in_rd   = '0;
        in_op   = '0;
        in_pc   = '0;
        in_imm  = '0;
        in_pd   = 1'b0;
        wb_en   = 1'b0;
        wb_tag  = '0;
        wb_data = '0;
        test_name = "reset";
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        test_name = "random_traffic";
        repeat (1000) begin
            @(posedge clk);
            next_issue(60);
            if ($urandom_range(0, 1) == 1) begin
                next_writeback(1'b1);
            end else begin
                wb_en <= 1'b0;
            end
            clr <= ($urandom_range(0, 99) == 0);
        end
        drain();
        test_name = "register_sweep";
        sweep_registers();
        drain();

        test_name = "back_pressure";
        repeat (ROB_DEPTH + 4) begin
            @(posedge clk);
            next_issue(100);
            wb_en <= 1'b0;
        end
        drain();

        test_name = "flush";
        repeat (5) begin
            @(posedge clk);
            next_issue(100);
            wb_en <= 1'b0;
        end
        @(posedge clk);
        clr <= 1'b1;                               // Issue still driven and dropped by the flush
        @(posedge clk);
        clr   <= 1'b0;
        in_en <= 1'b0;
        for (int k = 1; k <= ROB_DEPTH; k++) begin
            wb_en  <= 1'b1;
            wb_tag <= tag_t'(k);
            @(posedge clk);
        end
        wb_en <= 1'b0;
        sweep_registers();
        drain();
        repeat (4) @(posedge clk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/rename_core.sv
`timescale 1ns/100ps
`default_nettype none

module rename_core #(
    parameter int ROB_DEPTH = 7                // At most 2**TAG_W - 1
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  clr,

    input  wire                  in_en,
    input  wire ooo_pkg::regnm_t in_rs1,
    input  wire ooo_pkg::regnm_t in_rs2,
    input  wire ooo_pkg::regnm_t in_rd,
    input  wire ooo_pkg::op_t    in_op,
    input  wire ooo_pkg::pc_t    in_pc,
    input  wire ooo_pkg::imm_t   in_imm,
    input  wire                  in_pd,
    output logic                 in_rdy,

    output logic                 dp_en,
    output ooo_pkg::tag_t        dp_tag,
    output ooo_pkg::data_t       dp_rs1_dt,
    output ooo_pkg::data_t       dp_rs2_dt,
    output ooo_pkg::tag_t        dp_rs1_tag,
    output ooo_pkg::tag_t        dp_rs2_tag,
    output ooo_pkg::regnm_t      dp_rd,
    output ooo_pkg::op_t         dp_op,
    output ooo_pkg::pc_t         dp_pc,
    output ooo_pkg::imm_t        dp_imm,
    output logic                 dp_pd,

    input  wire                  wb_en,
    input  wire ooo_pkg::tag_t   wb_tag,
    input  wire ooo_pkg::data_t  wb_data,

    output logic                 cm_en,
    output ooo_pkg::regnm_t      cm_rd,
    output ooo_pkg::data_t       cm_data,
    output ooo_pkg::tag_t        cm_tag
);

    import ooo_pkg::*;

    logic alloc_en;
    tag_t alloc_tag;

    assign alloc_en = in_en && in_rdy;         // Accepted issue

    regfile u_regfile (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .alloc_en   (alloc_en),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_rd      (in_rd),
        .in_op      (in_op),
        .in_pc      (in_pc),
        .in_imm     (in_imm),
        .in_pd      (in_pd),
        .alloc_tag  (alloc_tag),
        .cm_en      (cm_en),
        .cm_rd      (cm_rd),
        .cm_data    (cm_data),
        .cm_tag     (cm_tag),
        .dp_en      (dp_en),
        .dp_tag     (dp_tag),
        .dp_rs1_tag (dp_rs1_tag),
        .dp_rs2_tag (dp_rs2_tag),
        .dp_rs1_dt  (dp_rs1_dt),
        .dp_rs2_dt  (dp_rs2_dt),
        .dp_rd      (dp_rd),
        .dp_op      (dp_op),
        .dp_pc      (dp_pc),
        .dp_imm     (dp_imm),
        .dp_pd      (dp_pd)
    );

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_reorder_buffer (
        .clk       (clk),
        .rst       (rst),
        .clr       (clr),
        .alloc_en  (alloc_en),
        .alloc_rd  (in_rd),
        .wb_en     (wb_en),
        .wb_tag    (wb_tag),
        .wb_data   (wb_data),
        .in_rdy    (in_rdy),
        .alloc_tag (alloc_tag),
        .cm_en     (cm_en),
        .cm_rd     (cm_rd),
        .cm_data   (cm_data),
        .cm_tag    (cm_tag)
    );

endmodule

`default_nettype wire

//--- hdl/reorder_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 7
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  clr,

    input  wire                  alloc_en,
    input  wire ooo_pkg::regnm_t alloc_rd,

    input  wire                  wb_en,
    input  wire ooo_pkg::tag_t   wb_tag,
    input  wire ooo_pkg::data_t  wb_data,

    output logic                 in_rdy,
    output ooo_pkg::tag_t        alloc_tag,
    output logic                 cm_en,
    output ooo_pkg::regnm_t      cm_rd,
    output ooo_pkg::data_t       cm_data,
    output ooo_pkg::tag_t        cm_tag
);

    import ooo_pkg::*;

    localparam int IDX_W = (ROB_DEPTH > 1) ? $clog2(ROB_DEPTH) : 1;
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [CNT_W-1:0] cnt_t;

    rob_slot_state_e slot_state [ROB_DEPTH];
    regnm_t          slot_rd    [ROB_DEPTH];
    data_t           slot_val   [ROB_DEPTH];

    idx_t head;
    idx_t tail;
    cnt_t count;

    logic push;
    logic pop;
    logic wb_hit;
    idx_t wb_slot;

    function automatic idx_t next_idx(idx_t idx);
        if (idx == idx_t'(ROB_DEPTH - 1)) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    assign in_rdy    = (count != cnt_t'(ROB_DEPTH));
    assign alloc_tag = tag_t'(tail) + 1'b1;    // Slot k carries tag k+1

    // Head retires once its result is in
    assign cm_en   = (slot_state[head] == DONE) && !clr;
    assign cm_rd   = slot_rd[head];
    assign cm_data = slot_val[head];
    assign cm_tag  = tag_t'(head) + 1'b1;

    assign push = alloc_en && in_rdy;
    assign pop  = cm_en;

    assign wb_slot = idx_t'(wb_tag - 1'b1);
    assign wb_hit  = wb_en && (wb_tag != '0) && (wb_tag <= tag_t'(ROB_DEPTH))
                     && (slot_state[wb_slot] == WAITING);

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_idx(tail);
            end
            if (pop) begin
                head <= next_idx(head);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                slot_state[i] <= EMPTY;
            end
        end else begin
            if (wb_hit) begin
                slot_state[wb_slot] <= DONE;
            end
            if (pop) begin
                slot_state[head] <= EMPTY;
            end
            if (push) begin
                slot_state[tail] <= WAITING;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !clr) begin
            slot_rd[tail] <= alloc_rd;
        end
        if (wb_hit && !clr) begin
            slot_val[wb_slot] <= wb_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  clr,

    input  wire                  alloc_en,
    input  wire ooo_pkg::regnm_t in_rs1,
    input  wire ooo_pkg::regnm_t in_rs2,
    input  wire ooo_pkg::regnm_t in_rd,
    input  wire ooo_pkg::op_t    in_op,
    input  wire ooo_pkg::pc_t    in_pc,
    input  wire ooo_pkg::imm_t   in_imm,
    input  wire                  in_pd,
    input  wire ooo_pkg::tag_t   alloc_tag,

    input  wire                  cm_en,
    input  wire ooo_pkg::regnm_t cm_rd,
    input  wire ooo_pkg::data_t  cm_data,
    input  wire ooo_pkg::tag_t   cm_tag,

    output logic                 dp_en,
    output ooo_pkg::tag_t        dp_tag,
    output ooo_pkg::tag_t        dp_rs1_tag,
    output ooo_pkg::tag_t        dp_rs2_tag,
    output ooo_pkg::data_t       dp_rs1_dt,
    output ooo_pkg::data_t       dp_rs2_dt,
    output ooo_pkg::regnm_t      dp_rd,
    output ooo_pkg::op_t         dp_op,
    output ooo_pkg::pc_t         dp_pc,
    output ooo_pkg::imm_t        dp_imm,
    output logic                 dp_pd
);

    import ooo_pkg::*;

    data_t reg_dt  [REG_NUM];
    tag_t  reg_tag [REG_NUM];

    logic  rename_we;
    logic  commit_we;

    assign rename_we = alloc_en && (in_rd != '0) && !is_store(in_op);
    // Stale results lose against a newer rename of the same register
    assign commit_we = cm_en && (cm_rd != '0) && (reg_tag[cm_rd] == cm_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            dp_en <= 1'b0;
        end else if (clr) begin
            dp_en <= 1'b0;
        end else begin
            dp_en <= alloc_en;
        end
    end

    // Operands sampled before this edge's tag and commit writes land
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            dp_tag     <= alloc_tag;
            dp_rs1_dt  <= reg_dt[in_rs1];
            dp_rs2_dt  <= reg_dt[in_rs2];
            dp_rs1_tag <= reg_tag[in_rs1];
            dp_rs2_tag <= reg_tag[in_rs2];
            dp_rd      <= in_rd;
            dp_op      <= in_op;
            dp_pc      <= in_pc;
            dp_imm     <= in_imm;
            dp_pd      <= in_pd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_NUM; i++) begin
                reg_dt[i]  <= '0;
                reg_tag[i] <= '0;
            end
        end else if (clr) begin
            for (int i = 0; i < REG_NUM; i++) begin
                reg_tag[i] <= '0;          // Values survive a flush
            end
        end else begin
            if (commit_we) begin
                reg_dt[cm_rd]  <= cm_data;
                reg_tag[cm_rd] <= '0;
            end
            if (rename_we) begin
                reg_tag[in_rd] <= alloc_tag;   // Wins over a same-edge commit
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    localparam int XLEN    = 32;
    localparam int REG_NUM = 32;
    localparam int TAG_W   = 3;

    typedef logic [XLEN-1:0]  data_t;
    typedef logic [4:0]       regnm_t;
    typedef logic [31:0]      pc_t;
    typedef logic [31:0]      imm_t;
    typedef logic [5:0]       op_t;
    typedef logic [TAG_W-1:0] tag_t;     // Zero means no pending producer

    // Store class never renames a destination
    localparam op_t OP_SB = 6'd25;
    localparam op_t OP_SH = 6'd26;
    localparam op_t OP_SW = 6'd27;

    typedef enum logic [1:0] {
        EMPTY,
        WAITING,                         // Allocated and awaiting its result
        DONE
    } rob_slot_state_e;

    function automatic logic is_store(op_t op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

endpackage

`default_nettype wire
